// ==== design/exec_wb_pkg.sv ====
// shared definitions for the execute-to-writeback slice
// modules import this inside their body, ports use scoped names
package exec_wb_pkg;

    // register file index width, 32 architectural registers
    localparam int REG_ADDR_WIDTH = 5;

    // csr address space per the privileged spec
    localparam int CSR_ADDR_WIDTH = 12;

    // tag carried by long instructions for completion tracking
    localparam int INST_ID_WIDTH = 2;

    // multiply/divide operations, unsigned divide only
    typedef enum logic [1:0] {
        MD_MUL  = 2'd0,
        MD_DIVU = 2'd1,
        MD_REMU = 2'd2
    } md_op_e;

    // level of int_assert_i meaning an interrupt is being taken
    localparam logic INT_ASSERT = 1'b1;

endpackage

// ==== design/md_seq_fsm.sv ====
// sequencer for one multiply/divide operation
// loads the datapath and counter on start, steps until terminal count,
// then offers the result to writeback and holds it until accepted
`timescale 1ns/10ps

module md_seq_fsm (
    input  logic clk,
    input  logic reset_i,
    input  logic start_i,
    input  logic last_i,
    input  logic wb_ready_i,
    output logic busy_o,
    output logic load_o,
    output logic step_o,
    output logic result_we_o
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } state_e;

    state_e state_q;
    state_e state_d;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_i) begin
                    state_d = ST_RUN;
                end
            end
            // counter reaching zero ends the iterations
            ST_RUN: begin
                if (last_i) begin
                    state_d = ST_DONE;
                end
            end
            // wait here while writeback refuses the result
            ST_DONE: begin
                if (wb_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // operands only captured while idle
    assign load_o = (state_q == ST_IDLE) && start_i;
    // terminal cycle only moves to done without a step
    assign step_o = (state_q == ST_RUN) && !last_i;
    assign busy_o = (state_q != ST_IDLE);
    assign result_we_o = (state_q == ST_DONE);

    // issuer must wait for busy to drop before the next start
    a_no_start_busy : assert property (@(posedge clk) disable iff (reset_i)
        start_i |-> !busy_o)
        else $error("md start issued while busy");

    // done is entered only from run on the counter's terminal flag
    a_result_in_done : assert property (@(posedge clk) disable iff (reset_i)
        $rose(result_we_o) |-> $past((state_q == ST_RUN) && last_i))
        else $error("md result offered without terminal count");

endmodule

// ==== design/md_iter_counter.sv ====
// iteration down-counter for the multiply/divide unit
// loaded with the operand width, flags last when it reaches zero
`timescale 1ns/10ps

module md_iter_counter #(
    parameter int DATA_WIDTH = 32
) (
    input  logic clk,
    input  logic reset_i,
    input  logic load_i,
    input  logic step_i,
    output logic last_o
);

    // must hold the value DATA_WIDTH itself
    localparam int CNT_WIDTH = $clog2(DATA_WIDTH + 1);

    logic [CNT_WIDTH-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= CNT_WIDTH'(DATA_WIDTH);
        end else if (step_i) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // terminal count, all steps done
    assign last_o = (cnt_q == '0);

    a_no_step_at_zero : assert property (@(posedge clk) disable iff (reset_i)
        step_i |-> !last_o)
        else $error("md counter stepped past zero");

endmodule

// ==== design/md_shift_datapath.sv ====
// shift datapath for MUL, DIVU and REMU, one bit per step
// the same operand registers serve the multiplier and the restoring divider
// the sequencer supplies load and step strobes
`timescale 1ns/10ps

module md_shift_datapath #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                                   clk,
    input  logic                                   reset_i,
    input  logic                                   load_i,
    input  logic                                   step_i,
    input  exec_wb_pkg::md_op_e                    op_i,
    input  logic [DATA_WIDTH-1:0]                  a_i,
    input  logic [DATA_WIDTH-1:0]                  b_i,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [exec_wb_pkg::INST_ID_WIDTH-1:0]  id_i,
    output logic [DATA_WIDTH-1:0]                  result_o,
    output logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] waddr_o,
    output logic [exec_wb_pkg::INST_ID_WIDTH-1:0]  id_o
);

    import exec_wb_pkg::*;

    md_op_e op_q;
    // mul: multiplier shifting right / div: dividend in, quotient out
    logic [DATA_WIDTH-1:0] a_q;
    // mul: multiplicand shifting left / div: divisor, static
    logic [DATA_WIDTH-1:0] b_q;
    // mul: partial product / div: partial remainder
    logic [DATA_WIDTH-1:0] acc_q;
    logic [REG_ADDR_WIDTH-1:0] waddr_q;
    logic [INST_ID_WIDTH-1:0] id_q;
    // shifted remainder minus divisor, top bit is the borrow
    logic [DATA_WIDTH+1:0] trial;

    assign trial = {1'b0, acc_q, a_q[DATA_WIDTH-1]} - {2'b00, b_q};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            op_q <= MD_MUL;
        end else if (load_i) begin
            op_q <= op_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            a_q <= a_i;
            b_q <= b_i;
            acc_q <= '0;
            waddr_q <= waddr_i;
            id_q <= id_i;
        end else if (step_i) begin
            if (op_q == MD_MUL) begin
                // add shifted multiplicand when the multiplier bit is set
                if (a_q[0]) begin
                    acc_q <= acc_q + b_q;
                end
                a_q <= a_q >> 1;
                b_q <= b_q << 1;
            end else if (!trial[DATA_WIDTH+1]) begin
                // divisor fits, keep difference and shift in a one
                acc_q <= trial[DATA_WIDTH-1:0];
                a_q <= {a_q[DATA_WIDTH-2:0], 1'b1};
            end else begin
                // restore, shift the next dividend bit into the remainder
                acc_q <= {acc_q[DATA_WIDTH-2:0], a_q[DATA_WIDTH-1]};
                a_q <= {a_q[DATA_WIDTH-2:0], 1'b0};
            end
        end
    end

    // zero divisor never borrows, so quotient ends all ones
    // and the remainder ends as the dividend, matching RISC-V
    always_comb begin
        case (op_q)
            MD_DIVU: result_o = a_q;
            MD_REMU: result_o = acc_q;
            default: result_o = acc_q;
        endcase
    end

    assign waddr_o = waddr_q;
    assign id_o = id_q;

endmodule

// ==== design/wbu.sv ====
// writeback unit, fixed priority agu > muldiv > csr > alu
// picks one register write per cycle, returns ready to the losers,
// forwards csr writes and reports long instruction completion
`timescale 1ns/10ps

module wbu #(
    parameter int DATA_WIDTH = 32
) (
    // alu result
    input  logic [DATA_WIDTH-1:0]                  alu_reg_wdata_i,
    input  logic                                   alu_reg_we_i,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] alu_reg_waddr_i,
    output logic                                   alu_ready_o,
    // multiply/divide result
    input  logic [DATA_WIDTH-1:0]                  muldiv_reg_wdata_i,
    input  logic                                   muldiv_reg_we_i,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] muldiv_reg_waddr_i,
    input  logic [exec_wb_pkg::INST_ID_WIDTH-1:0]  muldiv_inst_id_i,
    output logic                                   muldiv_ready_o,
    // csr instruction
    input  logic [DATA_WIDTH-1:0]                  csr_wdata_i,
    input  logic                                   csr_we_i,
    input  logic [exec_wb_pkg::CSR_ADDR_WIDTH-1:0] csr_waddr_i,
    output logic                                   csr_ready_o,
    input  logic [DATA_WIDTH-1:0]                  csr_reg_wdata_i,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] csr_reg_waddr_i,
    // load/agu result, never stalled
    input  logic [DATA_WIDTH-1:0]                  agu_reg_wdata_i,
    input  logic                                   agu_reg_we_i,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] agu_reg_waddr_i,
    input  logic [exec_wb_pkg::INST_ID_WIDTH-1:0]  agu_inst_id_i,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] idu_reg_waddr_i,
    input  logic                                   int_assert_i,
    // completion of long instructions
    output logic                                   commit_valid_o,
    output logic [exec_wb_pkg::INST_ID_WIDTH-1:0]  commit_id_o,
    // register file write port
    output logic [DATA_WIDTH-1:0]                  reg_wdata_o,
    output logic                                   reg_we_o,
    output logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] reg_waddr_o,
    // csr file write port
    output logic [DATA_WIDTH-1:0]                  csr_wdata_o,
    output logic                                   csr_we_o,
    output logic [exec_wb_pkg::CSR_ADDR_WIDTH-1:0] csr_waddr_o
);

    import exec_wb_pkg::*;

    logic agu_en, muldiv_en, csr_en, alu_en, idu_en;
    logic no_int;

    assign no_int = (int_assert_i != INT_ASSERT);

    // each source wins only if nothing above it is active
    assign agu_en = agu_reg_we_i;
    assign muldiv_en = muldiv_reg_we_i && !agu_reg_we_i;
    assign csr_en = csr_we_i && !(agu_reg_we_i || muldiv_reg_we_i);
    assign alu_en = alu_reg_we_i && !(agu_reg_we_i || muldiv_reg_we_i || csr_we_i);
    // idle port, address falls back to decode
    assign idu_en = !(agu_en || muldiv_en || csr_en || alu_en);

    // ready drops only on a real conflict with a higher source
    assign muldiv_ready_o = !(muldiv_reg_we_i && agu_reg_we_i);
    assign csr_ready_o = !(csr_we_i && (agu_reg_we_i || muldiv_reg_we_i));
    assign alu_ready_o = !(alu_reg_we_i && (agu_reg_we_i || muldiv_reg_we_i || csr_we_i));

    // and-or select, enables are one-hot or zero
    assign reg_wdata_o = ({DATA_WIDTH{agu_en}} & agu_reg_wdata_i)
                       | ({DATA_WIDTH{muldiv_en}} & muldiv_reg_wdata_i)
                       | ({DATA_WIDTH{csr_en}} & csr_reg_wdata_i)
                       | ({DATA_WIDTH{alu_en}} & alu_reg_wdata_i);

    assign reg_waddr_o = ({REG_ADDR_WIDTH{agu_en}} & agu_reg_waddr_i)
                       | ({REG_ADDR_WIDTH{muldiv_en}} & muldiv_reg_waddr_i)
                       | ({REG_ADDR_WIDTH{csr_en}} & csr_reg_waddr_i)
                       | ({REG_ADDR_WIDTH{alu_en}} & alu_reg_waddr_i)
                       | ({REG_ADDR_WIDTH{idu_en}} & idu_reg_waddr_i);

    // interrupt kills every write and commit
    assign reg_we_o = no_int && !idu_en;
    assign csr_we_o = no_int && csr_en;
    assign csr_wdata_o = csr_wdata_i;
    assign csr_waddr_o = csr_waddr_i;

    assign commit_valid_o = no_int && (agu_reg_we_i || muldiv_reg_we_i);
    assign commit_id_o = agu_reg_we_i ? agu_inst_id_i : muldiv_inst_id_i;

    always_comb begin
        a_onehot_en : assert final ($onehot0({agu_en, muldiv_en, csr_en, alu_en}))
            else $error("wbu enabled more than one source");
    end

endmodule

// ==== design/regfile.sv ====
// integer register file, one write port and two read ports
// x0 stays zero, reads are combinational
`timescale 1ns/10ps

module regfile #(
    parameter int DATA_WIDTH = 32,
    parameter int NUM_REGS = 32
) (
    input  logic                                   clk,
    input  logic                                   reset_i,
    input  logic                                   we_i,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [DATA_WIDTH-1:0]                  wdata_i,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] rs1_addr_i,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] rs2_addr_i,
    output logic [DATA_WIDTH-1:0]                  rs1_data_o,
    output logic [DATA_WIDTH-1:0]                  rs2_data_o
);

    logic [DATA_WIDTH-1:0] regs_q [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            // x0 write silently dropped
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // new value visible the cycle after the write edge
    assign rs1_data_o = regs_q[rs1_addr_i];
    assign rs2_data_o = regs_q[rs2_addr_i];

endmodule

// ==== design/exec_wb_top.sv ====
// execute-to-writeback slice: multiply/divide unit, writeback arbiter
// and register file; alu, csr and agu results come in from outside
`timescale 1ns/10ps

module exec_wb_top #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                                   clk,
    input  logic                                   reset_i,
    // alu source
    input  logic [DATA_WIDTH-1:0]                  alu_reg_wdata_i,
    input  logic                                   alu_reg_we_i,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] alu_reg_waddr_i,
    output logic                                   alu_ready_o,
    // csr source
    input  logic [DATA_WIDTH-1:0]                  csr_wdata_i,
    input  logic                                   csr_we_i,
    input  logic [exec_wb_pkg::CSR_ADDR_WIDTH-1:0] csr_waddr_i,
    output logic                                   csr_ready_o,
    input  logic [DATA_WIDTH-1:0]                  csr_reg_wdata_i,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] csr_reg_waddr_i,
    // agu source
    input  logic [DATA_WIDTH-1:0]                  agu_reg_wdata_i,
    input  logic                                   agu_reg_we_i,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] agu_reg_waddr_i,
    input  logic [exec_wb_pkg::INST_ID_WIDTH-1:0]  agu_inst_id_i,
    // multiply/divide issue
    input  logic                                   md_start_i,
    input  exec_wb_pkg::md_op_e                    md_op_i,
    input  logic [DATA_WIDTH-1:0]                  md_a_i,
    input  logic [DATA_WIDTH-1:0]                  md_b_i,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] md_waddr_i,
    input  logic [exec_wb_pkg::INST_ID_WIDTH-1:0]  md_id_i,
    output logic                                   md_busy_o,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] idu_reg_waddr_i,
    input  logic                                   int_assert_i,
    // writeback observation
    output logic                                   reg_we_o,
    output logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] reg_waddr_o,
    output logic [DATA_WIDTH-1:0]                  reg_wdata_o,
    output logic                                   csr_we_o,
    output logic [exec_wb_pkg::CSR_ADDR_WIDTH-1:0] csr_waddr_o,
    output logic [DATA_WIDTH-1:0]                  csr_wdata_o,
    output logic                                   commit_valid_o,
    output logic [exec_wb_pkg::INST_ID_WIDTH-1:0]  commit_id_o,
    // register read ports
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] rs1_addr_i,
    input  logic [exec_wb_pkg::REG_ADDR_WIDTH-1:0] rs2_addr_i,
    output logic [DATA_WIDTH-1:0]                  rs1_data_o,
    output logic [DATA_WIDTH-1:0]                  rs2_data_o
);

    import exec_wb_pkg::*;

    // sequencer strobes
    logic md_load, md_step, md_last;
    // result offered to writeback
    logic md_result_we, md_ready;
    logic [DATA_WIDTH-1:0] md_result;
    logic [REG_ADDR_WIDTH-1:0] md_res_waddr;
    logic [INST_ID_WIDTH-1:0] md_res_id;

    md_seq_fsm md_seq_fsm_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (md_start_i),
        .last_i      (md_last),
        .wb_ready_i  (md_ready),
        .busy_o      (md_busy_o),
        .load_o      (md_load),
        .step_o      (md_step),
        .result_we_o (md_result_we)
    );

    md_iter_counter #(.DATA_WIDTH(DATA_WIDTH)) md_iter_counter_i (
        .clk     (clk),
        .reset_i (reset_i),
        .load_i  (md_load),
        .step_i  (md_step),
        .last_o  (md_last)
    );

    md_shift_datapath #(.DATA_WIDTH(DATA_WIDTH)) md_shift_datapath_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .load_i   (md_load),
        .step_i   (md_step),
        .op_i     (md_op_i),
        .a_i      (md_a_i),
        .b_i      (md_b_i),
        .waddr_i  (md_waddr_i),
        .id_i     (md_id_i),
        .result_o (md_result),
        .waddr_o  (md_res_waddr),
        .id_o     (md_res_id)
    );

    wbu #(.DATA_WIDTH(DATA_WIDTH)) wbu_i (
        .alu_reg_wdata_i    (alu_reg_wdata_i),
        .alu_reg_we_i       (alu_reg_we_i),
        .alu_reg_waddr_i    (alu_reg_waddr_i),
        .alu_ready_o        (alu_ready_o),
        .muldiv_reg_wdata_i (md_result),
        .muldiv_reg_we_i    (md_result_we),
        .muldiv_reg_waddr_i (md_res_waddr),
        .muldiv_inst_id_i   (md_res_id),
        .muldiv_ready_o     (md_ready),
        .csr_wdata_i        (csr_wdata_i),
        .csr_we_i           (csr_we_i),
        .csr_waddr_i        (csr_waddr_i),
        .csr_ready_o        (csr_ready_o),
        .csr_reg_wdata_i    (csr_reg_wdata_i),
        .csr_reg_waddr_i    (csr_reg_waddr_i),
        .agu_reg_wdata_i    (agu_reg_wdata_i),
        .agu_reg_we_i       (agu_reg_we_i),
        .agu_reg_waddr_i    (agu_reg_waddr_i),
        .agu_inst_id_i      (agu_inst_id_i),
        .idu_reg_waddr_i    (idu_reg_waddr_i),
        .int_assert_i       (int_assert_i),
        .commit_valid_o     (commit_valid_o),
        .commit_id_o        (commit_id_o),
        .reg_wdata_o        (reg_wdata_o),
        .reg_we_o           (reg_we_o),
        .reg_waddr_o        (reg_waddr_o),
        .csr_wdata_o        (csr_wdata_o),
        .csr_we_o           (csr_we_o),
        .csr_waddr_o        (csr_waddr_o)
    );

    regfile #(.DATA_WIDTH(DATA_WIDTH), .NUM_REGS(32)) regfile_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .we_i       (reg_we_o),
        .waddr_i    (reg_waddr_o),
        .wdata_i    (reg_wdata_o),
        .rs1_addr_i (rs1_addr_i),
        .rs2_addr_i (rs2_addr_i),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

endmodule

// ==== bench/tb_exec_wb.sv ====
// testbench for the execute-to-writeback slice
// drives alu, csr, agu and multiply/divide sources against a reference model
// concurrent assertions compare the DUT with the model every cycle
`timescale 1ns/10ps

module tb_exec_wb;

    import exec_wb_pkg::*;

    localparam int DATA_WIDTH = 32;
    localparam int SEED = 53;
    localparam int TIMEOUT = 100;

    logic clk, reset_i;
    logic [DATA_WIDTH-1:0] alu_reg_wdata_i, csr_wdata_i, csr_reg_wdata_i, agu_reg_wdata_i;
    logic [DATA_WIDTH-1:0] md_a_i, md_b_i, reg_wdata_o, csr_wdata_o, rs1_data_o, rs2_data_o;
    logic alu_reg_we_i, csr_we_i, agu_reg_we_i, md_start_i, int_assert_i;
    logic alu_ready_o, csr_ready_o, md_busy_o, reg_we_o, csr_we_o, commit_valid_o;
    logic [REG_ADDR_WIDTH-1:0] alu_reg_waddr_i, csr_reg_waddr_i, agu_reg_waddr_i, md_waddr_i;
    logic [REG_ADDR_WIDTH-1:0] idu_reg_waddr_i, reg_waddr_o, rs1_addr_i, rs2_addr_i;
    logic [CSR_ADDR_WIDTH-1:0] csr_waddr_i, csr_waddr_o;
    logic [INST_ID_WIDTH-1:0] agu_inst_id_i, md_id_i, commit_id_o;
    md_op_e md_op_i;

    // reference model state
    logic [DATA_WIDTH-1:0] shadow [32];
    logic md_pending;
    int md_cnt;
    logic [DATA_WIDTH-1:0] md_exp_data, exp_wdata;
    logic [REG_ADDR_WIDTH-1:0] md_exp_addr, exp_waddr;
    logic [INST_ID_WIDTH-1:0] md_exp_id, exp_commit_id;
    logic md_exp_we, agu_act, md_act, csr_act, alu_act, exp_we, exp_csr_we, exp_commit;
    int errors, timeouts, tests_run, prev_fails;

    exec_wb_top #(.DATA_WIDTH(DATA_WIDTH)) exec_wb_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected mul/divu/remu result with the RISC-V zero divisor rule
    function automatic logic [DATA_WIDTH-1:0] md_ref(md_op_e op, logic [DATA_WIDTH-1:0] a,
                                                     logic [DATA_WIDTH-1:0] b);
        if (op == MD_MUL) return a * b;
        if (b == '0) return (op == MD_DIVU) ? '1 : a;
        return (op == MD_DIVU) ? a / b : a % b;
    endfunction

    // fixed priority agu > muldiv > csr > alu
    // interrupt kills writes and commits
    always_comb begin
        md_exp_we = md_pending && (md_cnt == 0);
        agu_act = agu_reg_we_i;
        md_act = md_exp_we && !agu_act;
        csr_act = csr_we_i && !agu_act && !md_exp_we;
        alu_act = alu_reg_we_i && !agu_act && !md_exp_we && !csr_we_i;
        exp_we = (agu_act || md_act || csr_act || alu_act) && !int_assert_i;
        exp_csr_we = csr_act && !int_assert_i;
        exp_commit = (agu_act || md_exp_we) && !int_assert_i;
        exp_commit_id = agu_act ? agu_inst_id_i : md_exp_id;
        exp_waddr = agu_act ? agu_reg_waddr_i : md_act ? md_exp_addr :
                    csr_act ? csr_reg_waddr_i : alu_act ? alu_reg_waddr_i : idu_reg_waddr_i;
        exp_wdata = agu_act ? agu_reg_wdata_i : md_act ? md_exp_data :
                    csr_act ? csr_reg_wdata_i : alu_act ? alu_reg_wdata_i : '0;
    end

    // result offered DATA_WIDTH+1 edges after start
    // held until agu goes quiet
    always @(posedge clk) begin
        if (reset_i) begin
            md_pending <= 1'b0;
            md_cnt <= 0;
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            if (exp_we && exp_waddr != '0) begin
                shadow[exp_waddr] <= exp_wdata;
            end
            if (md_start_i && !md_pending) begin
                md_pending <= 1'b1;
                md_cnt <= DATA_WIDTH + 1;
            end else if (md_cnt > 0) begin
                md_cnt <= md_cnt - 1;
            end else if (md_exp_we && !agu_reg_we_i) begin
                md_pending <= 1'b0;
            end
        end
    end

    function automatic void log_mismatch(string name, logic [DATA_WIDTH-1:0] expv,
                                         logic [DATA_WIDTH-1:0] actv);
        errors++;
        $display("Fail at %0d ns: %s expected %h, actual %h", $time, name, expv, actv);
    endfunction

    // falling edge sampling sees settled inputs and outputs
    a_we : assert property (@(negedge clk) disable iff (reset_i) reg_we_o == exp_we)
        else log_mismatch("reg_we_o", 32'(exp_we), 32'(reg_we_o));
    a_waddr : assert property (@(negedge clk) disable iff (reset_i) reg_waddr_o == exp_waddr)
        else log_mismatch("reg_waddr_o", 32'(exp_waddr), 32'(reg_waddr_o));
    a_wdata : assert property (@(negedge clk) disable iff (reset_i)
        exp_we |-> reg_wdata_o == exp_wdata)
        else log_mismatch("reg_wdata_o", exp_wdata, reg_wdata_o);
    a_csr_we : assert property (@(negedge clk) disable iff (reset_i) csr_we_o == exp_csr_we)
        else log_mismatch("csr_we_o", 32'(exp_csr_we), 32'(csr_we_o));
    // csr write port passes the csr source through
    a_csr_wdata : assert property (@(negedge clk) disable iff (reset_i)
        csr_wdata_o == csr_wdata_i)
        else log_mismatch("csr_wdata_o", csr_wdata_i, csr_wdata_o);
    a_csr_waddr : assert property (@(negedge clk) disable iff (reset_i)
        csr_waddr_o == csr_waddr_i)
        else log_mismatch("csr_waddr_o", 32'(csr_waddr_i), 32'(csr_waddr_o));
    a_commit : assert property (@(negedge clk) disable iff (reset_i)
        commit_valid_o == exp_commit)
        else log_mismatch("commit_valid_o", 32'(exp_commit), 32'(commit_valid_o));
    a_commit_id : assert property (@(negedge clk) disable iff (reset_i)
        exp_commit |-> commit_id_o == exp_commit_id)
        else log_mismatch("commit_id_o", 32'(exp_commit_id), 32'(commit_id_o));
    // ready low only for an active source that lost
    a_alu_rdy : assert property (@(negedge clk) disable iff (reset_i)
        alu_ready_o == !(alu_reg_we_i && !alu_act))
        else log_mismatch("alu_ready_o", 32'(!(alu_reg_we_i && !alu_act)), 32'(alu_ready_o));
    a_csr_rdy : assert property (@(negedge clk) disable iff (reset_i)
        csr_ready_o == !(csr_we_i && !csr_act))
        else log_mismatch("csr_ready_o", 32'(!(csr_we_i && !csr_act)), 32'(csr_ready_o));
    a_busy : assert property (@(negedge clk) disable iff (reset_i) md_busy_o == md_pending)
        else log_mismatch("md_busy_o", 32'(md_pending), 32'(md_busy_o));
    a_rs1 : assert property (@(negedge clk) disable iff (reset_i)
        rs1_data_o == shadow[rs1_addr_i])
        else log_mismatch("rs1_data_o", shadow[rs1_addr_i], rs1_data_o);
    a_rs2 : assert property (@(negedge clk) disable iff (reset_i)
        rs2_data_o == shadow[rs2_addr_i])
        else log_mismatch("rs2_data_o", shadow[rs2_addr_i], rs2_data_o);

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    // keep the source stable until the cycle where ready was high
    task automatic hold_until_ready(input bit is_csr);
        int n;
        logic rdy;
        n = 0;
        rdy = 1'b0;
        while (!rdy && n < TIMEOUT) begin
            @(negedge clk);
            rdy = is_csr ? csr_ready_o : alu_ready_o;
            tick();
            n++;
        end
        if (!rdy) begin
            timeouts++;
            $display("Timeout: %s source never saw ready", is_csr ? "csr" : "alu");
        end
    endtask

    task automatic wait_md_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (md_busy_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (md_busy_o) begin
            timeouts++;
            $display("Timeout: multiply/divide unit stayed busy");
        end
        tick();
    endtask

    task automatic issue_md(md_op_e op, logic [DATA_WIDTH-1:0] a, logic [DATA_WIDTH-1:0] b,
                            logic [REG_ADDR_WIDTH-1:0] addr, logic [INST_ID_WIDTH-1:0] id);
        md_exp_data = md_ref(op, a, b);
        md_exp_addr = addr;
        md_exp_id = id;
        md_op_i = op;
        md_a_i = a;
        md_b_i = b;
        md_waddr_i = addr;
        md_id_i = id;
        md_start_i = 1'b1;
        tick();
        md_start_i = 1'b0;
    endtask

    task automatic finish_test(string name);
        tests_run++;
        $display("test %0d %s: %s", tests_run, name,
                 (errors + timeouts == prev_fails) ? "ok" : "FAILED");
        prev_fails = errors + timeouts;
    endtask

    initial begin
        md_op_e op;
        logic [REG_ADDR_WIDTH-1:0] addr;
        void'($urandom(SEED));
        errors = 0;
        timeouts = 0;
        tests_run = 0;
        prev_fails = 0;
        reset_i = 1'b1;
        {alu_reg_we_i, csr_we_i, agu_reg_we_i, md_start_i, int_assert_i} = '0;
        {alu_reg_wdata_i, csr_wdata_i, csr_reg_wdata_i, agu_reg_wdata_i} = '0;
        {md_a_i, md_b_i, csr_waddr_i, agu_inst_id_i, md_id_i} = '0;
        {alu_reg_waddr_i, csr_reg_waddr_i, agu_reg_waddr_i, md_waddr_i} = '0;
        {idu_reg_waddr_i, rs1_addr_i, rs2_addr_i} = '0;
        md_op_i = MD_MUL;
        md_exp_data = '0;
        md_exp_addr = '0;
        md_exp_id = '0;
        repeat (10) @(posedge clk);
        #2 reset_i = 1'b0;

        // sweep both read ports over the cleared file
        for (int i = 0; i < 32; i++) begin
            rs1_addr_i = 5'(i);
            rs2_addr_i = 5'(31 - i);
            tick();
        end
        // first write goes to x0
        for (int i = 0; i < 8; i++) begin
            alu_reg_we_i = 1'b1;
            alu_reg_waddr_i = (i == 0) ? 5'd0 : 5'($urandom_range(31, 1));
            alu_reg_wdata_i = $urandom();
            tick();
            alu_reg_we_i = 1'b0;
            rs1_addr_i = alu_reg_waddr_i;
            tick();
        end
        finish_test("reset and alu writes");

        // three sources in one cycle
        // agu wins and the losers retry
        agu_reg_we_i = 1'b1;
        agu_reg_waddr_i = 5'd3;
        agu_reg_wdata_i = $urandom();
        agu_inst_id_i = 2'd2;
        csr_we_i = 1'b1;
        csr_reg_waddr_i = 5'd4;
        csr_reg_wdata_i = $urandom();
        csr_waddr_i = 12'h300;
        csr_wdata_i = $urandom();
        alu_reg_we_i = 1'b1;
        alu_reg_waddr_i = 5'd5;
        alu_reg_wdata_i = $urandom();
        rs1_addr_i = 5'd3;
        rs2_addr_i = 5'd4;
        tick();
        agu_reg_we_i = 1'b0;
        hold_until_ready(1'b1);
        csr_we_i = 1'b0;
        hold_until_ready(1'b0);
        alu_reg_we_i = 1'b0;
        rs1_addr_i = 5'd5;
        tick();
        finish_test("priority and retry");

        // last two divides use a zero divisor
        for (int i = 0; i < 6; i++) begin
            op = (i % 3 == 0) ? MD_MUL : (i % 3 == 1) ? MD_DIVU : MD_REMU;
            addr = 5'($urandom_range(31, 1));
            issue_md(op, $urandom(), (i >= 4) ? 32'd0 : $urandom(), addr, 2'(i));
            rs1_addr_i = addr;
            wait_md_idle();
        end
        finish_test("multiply/divide results");

        // agu held across the cycle where the mul result is offered
        rs1_addr_i = 5'd9;
        rs2_addr_i = 5'd7;
        issue_md(MD_MUL, $urandom(), $urandom(), 5'd9, 2'd1);
        repeat (28) tick();
        agu_reg_we_i = 1'b1;
        agu_reg_waddr_i = 5'd7;
        agu_reg_wdata_i = $urandom();
        agu_inst_id_i = 2'd3;
        repeat (10) tick();
        agu_reg_we_i = 1'b0;
        wait_md_idle();
        finish_test("agu stalls multiply/divide");

        // interrupt kills every source so the shadow stays unchanged
        int_assert_i = 1'b1;
        agu_reg_we_i = 1'b1;
        agu_reg_waddr_i = 5'd12;
        tick();
        agu_reg_we_i = 1'b0;
        csr_we_i = 1'b1;
        csr_reg_waddr_i = 5'd11;
        tick();
        csr_we_i = 1'b0;
        alu_reg_we_i = 1'b1;
        alu_reg_waddr_i = 5'd10;
        tick();
        alu_reg_we_i = 1'b0;
        rs1_addr_i = 5'd13;
        issue_md(MD_DIVU, $urandom(), $urandom(), 5'd13, 2'd0);
        wait_md_idle();
        int_assert_i = 1'b0;
        finish_test("interrupt kill");

        // idle port takes its address from decode
        for (int i = 0; i < 8; i++) begin
            idu_reg_waddr_i = 5'($urandom());
            tick();
        end
        finish_test("idle address");

        $display("tests run: %0d, failing checks: %0d, timeouts: %0d",
                 tests_run, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/exec_wb_pkg.sv
design/md_seq_fsm.sv
design/md_iter_counter.sv
design/md_shift_datapath.sv
design/wbu.sv
design/regfile.sv
design/exec_wb_top.sv
bench/tb_exec_wb.sv

// ==== Makefile ====
SIM      ?= verilator
TOP      ?= tb_exec_wb
LOG      ?= sim.log
SEED     ?= 53
BUILD    ?= obj_dir
FILELIST ?= tb.f
PASS_MSG  = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) from $(FILELIST), run it, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "overridable: SIM TOP LOG SEED BUILD FILELIST"

test:
	$(SIM) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
